// File: files.f
+incdir+hw
+incdir+test
hw/irq_pkg.sv
hw/vec_pkg.sv
hw/ripple_block_adder.sv
hw/carry_select_adder.sv
hw/group_arbiter.sv
hw/line_selector.sv
hw/vector_resolver.sv
hw/ivmu_top.sv
test/ivmu_tb.sv

// File: hw/carry_select_adder.sv
// Carry select address adder
`timescale 1ns/1ps
`include "ivmu_cfg.svh"

module carry_select_adder (
    input  vec_pkg::handler_addr_t a,
    input  vec_pkg::handler_addr_t b,
    input  logic                   carry_in,
    output vec_pkg::handler_addr_t sum,
    output logic                   carry_out
);

    localparam int blk_w    = `IVMU_ADDER_BLOCK;
    localparam int num_blks = $bits(vec_pkg::handler_addr_t) / blk_w;  // 4 blocks

    // Both candidate results of every block
    logic [blk_w-1:0]    sum_c0 [num_blks];  // Assuming carry 0
    logic [blk_w-1:0]    sum_c1 [num_blks];  // Assuming carry 1
    logic [num_blks-1:0] cout_c0;
    logic [num_blks-1:0] cout_c1;

    logic [num_blks:0]   blk_carry;          // Real carry into each block

    assign blk_carry[0] = carry_in;

    for (genvar i = 0; i < num_blks; i++) begin : g_blk
        // Speculative adder, no carry in
        ripple_block_adder u_add_c0 (
            .a         (a[i*blk_w +: blk_w]),
            .b         (b[i*blk_w +: blk_w]),
            .carry_in  (1'b0),
            .sum       (sum_c0[i]),
            .carry_out (cout_c0[i])
        );

        // Speculative adder, carry in forced high
        ripple_block_adder u_add_c1 (
            .a         (a[i*blk_w +: blk_w]),
            .b         (b[i*blk_w +: blk_w]),
            .carry_in  (1'b1),
            .sum       (sum_c1[i]),
            .carry_out (cout_c1[i])
        );

        // Carry from below picks the sum and the carry passed up
        assign sum[i*blk_w +: blk_w] = blk_carry[i] ? sum_c1[i] : sum_c0[i];
        assign blk_carry[i+1]        = blk_carry[i] ? cout_c1[i] : cout_c0[i];
    end

    assign carry_out = blk_carry[num_blks];

endmodule

// File: hw/group_arbiter.sv
// Fixed priority group arbiter
`timescale 1ns/1ps
`include "ivmu_cfg.svh"

module group_arbiter (
    input  logic                 clock,
    input  logic                 reset,
    input  irq_pkg::irq_lines_t  irq_lines,
    output irq_pkg::group_pick_t group_pick
);

    logic [`IVMU_GROUPS-1:0] pending;    // One bit per group
    irq_pkg::group_pick_t    pick_next;  // Combinational winner

    // A group is pending when any of its lines is up
    always_comb begin
        for (int g = 0; g < `IVMU_GROUPS; g++) begin
            pending[g] = |irq_lines[g*`IVMU_LINES_PER_GROUP +: `IVMU_LINES_PER_GROUP];
        end
    end

    // Walk from group 7 down so the lowest pending group is written last
    always_comb begin
        pick_next = '0;
        for (int g = `IVMU_GROUPS-1; g >= 0; g--) begin
            if (pending[g]) begin
                pick_next.found = 1'b1;
                pick_next.group = irq_pkg::group_idx_t'(g);
            end
        end
    end

    // Stage 1 register, new sample every clock
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            group_pick <= '0;
        end else begin
            group_pick <= pick_next;
        end
    end

    // Lowest set bit of the previous sample must sit at the registered group
    assert property (@(posedge clock) disable iff (reset)
        group_pick.found |->
            (($past(pending & (~pending + 1'b1)) >> group_pick.group) == 1'b1))
        else $error("group_arbiter: group %0d is not the lowest pending group",
                    group_pick.group);

endmodule

// File: hw/irq_pkg.sv
// Interrupt request types
`include "ivmu_cfg.svh"

package irq_pkg;

    // Group g owns lines 4g+3 down to 4g
    typedef logic [`IVMU_GROUPS*`IVMU_LINES_PER_GROUP-1:0] irq_lines_t;

    typedef logic [$clog2(`IVMU_GROUPS)-1:0]          group_idx_t;  // 0..7
    typedef logic [$clog2(`IVMU_LINES_PER_GROUP)-1:0] line_idx_t;   // 0..3

    // Winning group of one sample
    typedef struct packed {
        logic       found;  // Any line pending at all
        group_idx_t group;
    } group_pick_t;

    // Winning line of every group, side by side
    typedef struct packed {
        logic      [`IVMU_GROUPS-1:0] found;  // Bit g set when group g has a line up
        line_idx_t [`IVMU_GROUPS-1:0] line;   // Entry g valid only with found[g]
    } line_pick_t;

endpackage

// File: hw/ivmu_cfg.svh
// Interrupt vector unit configuration
`ifndef IVMU_CFG_SVH
`define IVMU_CFG_SVH

// Request side
`define IVMU_GROUPS          8              // Group 0 has top priority
`define IVMU_LINES_PER_GROUP 4              // Line 3 wins inside a group

// Vector side
`define IVMU_BASE_ADDRESS    32'hFFF8_0000  // Handler table base
`define IVMU_VEC_SHIFT       4              // 16 bytes per handler slot

// Address adder
`define IVMU_ADDER_BLOCK     8              // Ripple block width in bits

`endif

// File: hw/ivmu_top.sv
// Interrupt vector unit top
`timescale 1ns/1ps

module ivmu_top (
    input  logic                   clock,
    input  logic                   reset,
    input  irq_pkg::irq_lines_t    irq_lines,
    output vec_pkg::handler_addr_t handler_addr,
    output logic                   irq_active
);

    irq_pkg::group_pick_t group_pick;  // Stage 1 group winner
    irq_pkg::line_pick_t  line_pick;   // Stage 1 line winners, all groups

    // Stage 1, both blocks see the same sample
    group_arbiter u_group_arbiter (
        .clock      (clock),
        .reset      (reset),
        .irq_lines  (irq_lines),
        .group_pick (group_pick)
    );

    line_selector u_line_selector (
        .clock     (clock),
        .reset     (reset),
        .irq_lines (irq_lines),
        .line_pick (line_pick)
    );

    // Stages 2 and 3
    vector_resolver u_vector_resolver (
        .clock        (clock),
        .reset        (reset),
        .group_pick   (group_pick),
        .line_pick    (line_pick),
        .handler_addr (handler_addr),
        .irq_active   (irq_active)
    );

endmodule

// File: hw/line_selector.sv
// Per group line selector
`timescale 1ns/1ps
`include "ivmu_cfg.svh"

module line_selector (
    input  logic                clock,
    input  logic                reset,
    input  irq_pkg::irq_lines_t irq_lines,
    output irq_pkg::line_pick_t line_pick
);

    irq_pkg::line_pick_t pick_next;  // All 8 groups resolved at once

    // Inside each group the highest set line wins
    always_comb begin
        pick_next = '0;
        for (int g = 0; g < `IVMU_GROUPS; g++) begin
            // Ascending scan, later hits overwrite lower lines
            for (int l = 0; l < `IVMU_LINES_PER_GROUP; l++) begin
                if (irq_lines[g*`IVMU_LINES_PER_GROUP + l]) begin
                    pick_next.found[g] = 1'b1;
                    pick_next.line[g]  = irq_pkg::line_idx_t'(l);
                end
            end
        end
    end

    // Stage 1 register, runs beside the group arbiter
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            line_pick <= '0;
        end else begin
            line_pick <= pick_next;
        end
    end

    // Chosen line was up last clock and nothing above it was
    for (genvar g = 0; g < `IVMU_GROUPS; g++) begin : g_line_chk
        assert property (@(posedge clock) disable iff (reset)
            line_pick.found[g] |->
                (($past(irq_lines[g*`IVMU_LINES_PER_GROUP +: `IVMU_LINES_PER_GROUP])
                  >> line_pick.line[g]) == 1'b1))
            else $error("line_selector: group %0d picked line %0d which was not top set",
                        g, line_pick.line[g]);
    end

endmodule

// File: hw/ripple_block_adder.sv
// Ripple carry adder block
`timescale 1ns/1ps
`include "ivmu_cfg.svh"

module ripple_block_adder (
    input  logic [`IVMU_ADDER_BLOCK-1:0] a,
    input  logic [`IVMU_ADDER_BLOCK-1:0] b,
    input  logic                         carry_in,
    output logic [`IVMU_ADDER_BLOCK-1:0] sum,
    output logic                         carry_out
);

    logic [`IVMU_ADDER_BLOCK-1:0] prop;   // Propagate per bit
    logic [`IVMU_ADDER_BLOCK-1:0] gen;    // Generate per bit
    logic [`IVMU_ADDER_BLOCK:0]   carry;  // carry[i] enters bit i

    assign prop     = a ^ b;
    assign gen      = a & b;
    assign carry[0] = carry_in;

    // Carry ripples one bit at a time
    for (genvar i = 0; i < `IVMU_ADDER_BLOCK; i++) begin : g_bit
        assign carry[i+1] = gen[i] | (prop[i] & carry[i]);
    end

    assign sum       = prop ^ carry[`IVMU_ADDER_BLOCK-1:0];
    assign carry_out = carry[`IVMU_ADDER_BLOCK];  // Out of the top bit

endmodule

// File: hw/vec_pkg.sv
// Interrupt vector types
`include "ivmu_cfg.svh"

package vec_pkg;

    // Flat vector number, group * 4 + line
    typedef logic [$clog2(`IVMU_GROUPS*`IVMU_LINES_PER_GROUP)-1:0] vec_idx_t;

    typedef logic [31:0] handler_addr_t;  // Byte address of the handler

    // Resolved request between the merge and the address stage
    typedef struct packed {
        logic     valid;
        vec_idx_t index;
    } vec_req_t;

endpackage

// File: hw/vector_resolver.sv
// Vector index and handler address
`timescale 1ns/1ps
`include "ivmu_cfg.svh"

module vector_resolver (
    input  logic                   clock,
    input  logic                   reset,
    input  irq_pkg::group_pick_t   group_pick,
    input  irq_pkg::line_pick_t    line_pick,
    output vec_pkg::handler_addr_t handler_addr,
    output logic                   irq_active
);

    // Handler window, base up to the last vector slot
    localparam vec_pkg::handler_addr_t addr_lo = `IVMU_BASE_ADDRESS;
    localparam vec_pkg::handler_addr_t addr_hi =
        `IVMU_BASE_ADDRESS + ((`IVMU_GROUPS*`IVMU_LINES_PER_GROUP - 1) << `IVMU_VEC_SHIFT);

    irq_pkg::line_idx_t     sel_line;   // Line of the winning group
    logic                   sel_found;
    vec_pkg::vec_req_t      req_next;
    vec_pkg::vec_req_t      req;        // Stage 2 register
    vec_pkg::handler_addr_t offset;     // index * 16
    vec_pkg::handler_addr_t addr_sum;

    // Stage 2, pick the winning group's entry from the line results
    assign sel_line  = line_pick.line[group_pick.group];
    assign sel_found = line_pick.found[group_pick.group];

    always_comb begin
        req_next.valid = group_pick.found & sel_found;
        // group * 4 + line, the line fills the low bits
        req_next.index = (vec_pkg::vec_idx_t'(group_pick.group) << $bits(irq_pkg::line_idx_t))
                       | vec_pkg::vec_idx_t'(sel_line);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            req <= '0;
        end else begin
            req <= req_next;
        end
    end

    // Stage 3, base plus scaled index
    assign offset = vec_pkg::handler_addr_t'(req.index) << `IVMU_VEC_SHIFT;

    carry_select_adder u_addr_adder (
        .a         (addr_lo),
        .b         (offset),
        .carry_in  (1'b0),
        .sum       (addr_sum),
        .carry_out ()           // Sum never wraps inside the window
    );

    // Output register, idle samples give a zero address
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            handler_addr <= '0;
            irq_active   <= 1'b0;
        end else if (req.valid) begin
            handler_addr <= addr_sum;
            irq_active   <= 1'b1;
        end else begin
            handler_addr <= '0;
            irq_active   <= 1'b0;
        end
    end

    // Active address stays inside the handler table and on a slot boundary
    assert property (@(posedge clock) disable iff (reset)
        irq_active |->
            (handler_addr >= addr_lo) && (handler_addr <= addr_hi) &&
            (handler_addr[`IVMU_VEC_SHIFT-1:0] == '0))
        else $error("vector_resolver: handler address %h outside table", handler_addr);

endmodule

// File: test/ivmu_vectors.svh
// Directed vector table
`ifndef IVMU_VECTORS_SVH
`define IVMU_VECTORS_SVH

// Columns are test, irq_lines, expected irq_active, expected handler_addr
task automatic load_directed_table();
    // Idle after reset
    add_entry(test_reset_idle, 32'h0000_0000, 1'b0, 32'h0000_0000);
    add_entry(test_reset_idle, 32'h0000_0000, 1'b0, 32'h0000_0000);
    add_entry(test_reset_idle, 32'h0000_0000, 1'b0, 32'h0000_0000);

    // Lowest group number wins
    add_entry(test_group_priority, 32'h4000_0020, 1'b1, 32'hFFF8_0050);  // Lines 5 and 30
    add_entry(test_group_priority, 32'h8000_0010, 1'b1, 32'hFFF8_0040);  // Lines 4 and 31
    add_entry(test_group_priority, 32'h8000_0001, 1'b1, 32'hFFF8_0000);  // Lines 0 and 31
    add_entry(test_group_priority, 32'hFFFF_FFFF, 1'b1, 32'hFFF8_0030);  // Everything up
    add_entry(test_group_priority, 32'h0010_1000, 1'b1, 32'hFFF8_00C0);  // Lines 12 and 20

    // Highest line inside the group wins
    add_entry(test_line_priority, 32'h0000_0B00, 1'b1, 32'hFFF8_00B0);   // Lines 8, 9, 11
    add_entry(test_line_priority, 32'h3000_0000, 1'b1, 32'hFFF8_01D0);   // Lines 28, 29
    add_entry(test_line_priority, 32'h000F_0000, 1'b1, 32'hFFF8_0130);   // Whole group 4
    add_entry(test_line_priority, 32'h0050_0000, 1'b1, 32'hFFF8_0160);   // Lines 20, 22

    // One line at a time, walks carries across the adder blocks
    add_entry(test_address_range, 32'h0000_0001, 1'b1, 32'hFFF8_0000);
    add_entry(test_address_range, 32'h0000_0002, 1'b1, 32'hFFF8_0010);
    add_entry(test_address_range, 32'h0000_0004, 1'b1, 32'hFFF8_0020);
    add_entry(test_address_range, 32'h0000_0008, 1'b1, 32'hFFF8_0030);
    add_entry(test_address_range, 32'h0000_0010, 1'b1, 32'hFFF8_0040);
    add_entry(test_address_range, 32'h0000_0020, 1'b1, 32'hFFF8_0050);
    add_entry(test_address_range, 32'h0000_0040, 1'b1, 32'hFFF8_0060);
    add_entry(test_address_range, 32'h0000_0080, 1'b1, 32'hFFF8_0070);
    add_entry(test_address_range, 32'h0000_0100, 1'b1, 32'hFFF8_0080);
    add_entry(test_address_range, 32'h0000_0200, 1'b1, 32'hFFF8_0090);
    add_entry(test_address_range, 32'h0000_0400, 1'b1, 32'hFFF8_00A0);
    add_entry(test_address_range, 32'h0000_0800, 1'b1, 32'hFFF8_00B0);
    add_entry(test_address_range, 32'h0000_1000, 1'b1, 32'hFFF8_00C0);
    add_entry(test_address_range, 32'h0000_2000, 1'b1, 32'hFFF8_00D0);
    add_entry(test_address_range, 32'h0000_4000, 1'b1, 32'hFFF8_00E0);
    add_entry(test_address_range, 32'h0000_8000, 1'b1, 32'hFFF8_00F0);
    add_entry(test_address_range, 32'h0001_0000, 1'b1, 32'hFFF8_0100);  // Crosses into byte 1
    add_entry(test_address_range, 32'h0002_0000, 1'b1, 32'hFFF8_0110);
    add_entry(test_address_range, 32'h0004_0000, 1'b1, 32'hFFF8_0120);
    add_entry(test_address_range, 32'h0008_0000, 1'b1, 32'hFFF8_0130);
    add_entry(test_address_range, 32'h0010_0000, 1'b1, 32'hFFF8_0140);
    add_entry(test_address_range, 32'h0020_0000, 1'b1, 32'hFFF8_0150);
    add_entry(test_address_range, 32'h0040_0000, 1'b1, 32'hFFF8_0160);
    add_entry(test_address_range, 32'h0080_0000, 1'b1, 32'hFFF8_0170);
    add_entry(test_address_range, 32'h0100_0000, 1'b1, 32'hFFF8_0180);
    add_entry(test_address_range, 32'h0200_0000, 1'b1, 32'hFFF8_0190);
    add_entry(test_address_range, 32'h0400_0000, 1'b1, 32'hFFF8_01A0);
    add_entry(test_address_range, 32'h0800_0000, 1'b1, 32'hFFF8_01B0);
    add_entry(test_address_range, 32'h1000_0000, 1'b1, 32'hFFF8_01C0);
    add_entry(test_address_range, 32'h2000_0000, 1'b1, 32'hFFF8_01D0);
    add_entry(test_address_range, 32'h4000_0000, 1'b1, 32'hFFF8_01E0);
    add_entry(test_address_range, 32'h8000_0000, 1'b1, 32'hFFF8_01F0);  // Last slot

    // Idle and active back to back
    add_entry(test_pipelining, 32'h0000_0000, 1'b0, 32'h0000_0000);
    add_entry(test_pipelining, 32'h0000_0080, 1'b1, 32'hFFF8_0070);
    add_entry(test_pipelining, 32'h0000_0000, 1'b0, 32'h0000_0000);
    add_entry(test_pipelining, 32'h0200_0000, 1'b1, 32'hFFF8_0190);
    add_entry(test_pipelining, 32'h0000_0000, 1'b0, 32'h0000_0000);
    add_entry(test_pipelining, 32'h0000_0006, 1'b1, 32'hFFF8_0020);
    add_entry(test_pipelining, 32'h0100_0000, 1'b1, 32'hFFF8_0180);  // Two active in a row
    add_entry(test_pipelining, 32'h0000_0000, 1'b0, 32'h0000_0000);
endtask

`endif

// File: test/ivmu_tb.sv
// Interrupt vector unit testbench
`timescale 1ns/1ps
`include "ivmu_cfg.svh"

module ivmu_tb;

    localparam int reset_cycles = 5;
    localparam int pipe_latency = 3;   // Edges from drive to visible output
    localparam int random_count = 40;

    // Test numbers, also index the name list
    localparam logic [3:0] test_reset_idle     = 4'd0;
    localparam logic [3:0] test_group_priority = 4'd1;
    localparam logic [3:0] test_line_priority  = 4'd2;
    localparam logic [3:0] test_address_range  = 4'd3;
    localparam logic [3:0] test_pipelining     = 4'd4;
    localparam logic [3:0] test_random         = 4'd5;
    localparam int         test_count          = 6;

    // One row of the stimulus table
    typedef struct packed {
        logic [3:0]             test;
        irq_pkg::irq_lines_t    lines;
        logic                   active;  // Expected irq_active
        vec_pkg::handler_addr_t addr;    // Expected handler_addr
    } entry_t;

    logic                   clock;
    logic                   reset;
    irq_pkg::irq_lines_t    irq_lines;
    vec_pkg::handler_addr_t handler_addr;
    logic                   irq_active;

    entry_t vectors[$];
    string  test_names[test_count] = '{"reset_idle", "group_priority", "line_priority",
                                       "address_range", "pipelining", "random"};
    int     test_checks[test_count];
    int     test_errors[test_count];
    int     cycle_count;
    int     cycle_limit;
    bit     table_ready;
    int     total_checks;
    int     total_errors;

    ivmu_top uut (
        .clock        (clock),
        .reset        (reset),
        .irq_lines    (irq_lines),
        .handler_addr (handler_addr),
        .irq_active   (irq_active)
    );

    task automatic add_entry(input logic [3:0] test, input irq_pkg::irq_lines_t lines,
                             input logic active, input vec_pkg::handler_addr_t addr);
        entry_t e;
        e.test   = test;
        e.lines  = lines;
        e.active = active;
        e.addr   = addr;
        vectors.push_back(e);
    endtask

    `include "ivmu_vectors.svh"

    // Reference model, lowest group first then highest line inside it
    function automatic entry_t model_entry(input logic [3:0] test,
                                           input irq_pkg::irq_lines_t lines);
        entry_t e;
        int     index;
        bit     hit;
        e     = '0;
        hit   = 1'b0;
        index = 0;
        for (int g = 0; g < `IVMU_GROUPS; g++) begin
            for (int l = `IVMU_LINES_PER_GROUP - 1; l >= 0; l--) begin
                if (!hit && lines[g*`IVMU_LINES_PER_GROUP + l]) begin
                    hit   = 1'b1;
                    index = g*`IVMU_LINES_PER_GROUP + l;
                end
            end
        end
        e.test   = test;
        e.lines  = lines;
        e.active = hit;
        e.addr   = hit ? `IVMU_BASE_ADDRESS + (index << `IVMU_VEC_SHIFT) : 32'h0;  // Idle is 0
        return e;
    endfunction

    task automatic add_random_entries();
        irq_pkg::irq_lines_t pattern;
        for (int i = 0; i < random_count; i++) begin
            pattern = $urandom & $urandom;          // Sparse, about one line in four
            pattern = pattern << ($urandom % 32);   // Clears low groups now and then
            vectors.push_back(model_entry(test_random, pattern));
        end
    endtask

    task automatic report_test(input int t);
        $display("test %s done: %0d checks, %0d errors", test_names[t], test_checks[t],
                 test_errors[t]);
    endtask

    // Outputs must be idle while reset is held
    task automatic check_reset_state();
        test_checks[test_reset_idle]++;
        assert (irq_active === 1'b0 && handler_addr === 32'h0) else begin
            $display("error at %0t: irq_active/handler_addr expected 0/00000000 actual %b/%h",
                     $time, irq_active, handler_addr);
            test_errors[test_reset_idle]++;
        end
    endtask

    task automatic check_entry(input int k);
        entry_t exp;
        int     t;
        exp = vectors[k];
        t   = exp.test;
        test_checks[t]++;
        assert (irq_active === exp.active) else begin
            $display("error at %0t: irq_active expected %b actual %b (entry %0d)",
                     $time, exp.active, irq_active, k);
            test_errors[t]++;
        end
        assert (handler_addr === exp.addr) else begin
            $display("error at %0t: handler_addr expected %h actual %h (entry %0d)",
                     $time, exp.addr, handler_addr, k);
            test_errors[t]++;
        end
        // Last row of its test closes the test
        if (k == vectors.size() - 1 || vectors[k+1].test != exp.test) begin
            report_test(t);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;  // 40 ns period
    end

    // Watchdog on clock edges
    initial begin
        wait (table_ready);
        cycle_limit = vectors.size() + reset_cycles + pipe_latency + 20;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        irq_lines = '0;
        void'($urandom(79));
        load_directed_table();
        add_random_entries();
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clock);
        #1;
        check_reset_state();
        reset = 1'b0;

        // Drive row k, check row k-3 whose result just left the pipeline
        for (int k = 0; k < vectors.size() + pipe_latency; k++) begin
            @(posedge clock);
            #1;
            if (k >= pipe_latency) begin
                check_entry(k - pipe_latency);
            end
            if (k < vectors.size()) begin
                irq_lines = vectors[k].lines;
            end else begin
                irq_lines = '0;  // Flush
            end
        end

        for (int t = 0; t < test_count; t++) begin
            total_checks += test_checks[t];
            total_errors += test_errors[t];
        end
        $display("checks %0d, errors %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
